// ==== sbox_params.svh ====
`ifndef SBOX_PARAMS_SVH
`define SBOX_PARAMS_SVH

// lane count of the concentrator
// held at four since the sorting network only handles four items
`define SBOX_LANES 4

// bits needed to name one lane
`define SBOX_LG_LANES 2

// width of the data word carried in each lane
`define SBOX_DATA_W 8

`endif

// ==== sbox_pkg.sv ====
`include "sbox_params.svh"

package sbox_pkg;

   // index of a single lane position
   typedef logic [`SBOX_LG_LANES-1:0] lane_idx_t;

   // one index per lane, element j refers to lane position j
   typedef lane_idx_t [`SBOX_LANES-1:0] lane_perm_t;

   // all lane data words of one bundle
   typedef logic [`SBOX_LANES-1:0][`SBOX_DATA_W-1:0] lane_data_t;

   // bundle as it arrives from the switch box
   // mask bit j set means lane j is occupied
   typedef struct packed {
      lane_data_t data;
      logic [`SBOX_LANES-1:0] mask;
   } in_bundle_s;

   // permutations derived from the occupancy mask
   // fwd_perm[j] is the input lane that lands on output j
   // bkwd_perm[k] is the output position that input lane k went to
   typedef struct packed {
      lane_perm_t fwd_perm;
      logic [`SBOX_LANES-1:0] fwd_valid;
      lane_perm_t bkwd_perm;
   } route_s;

   // concentrated bundle handed downstream
   // count spans 0 to SBOX_LANES, hence one extra bit
   typedef struct packed {
      lane_data_t data;
      logic [`SBOX_LANES-1:0] lane_valid;
      logic [`SBOX_LG_LANES:0] count;
      lane_perm_t bkwd_perm;
   } out_bundle_s;

endpackage

// ==== bsg_sort_stable.sv ====
`timescale 1ns/1ps

// four item sorting network
// items are ordered ascending by key field [t_p:b_p], the whole item travels
module bsg_sort_stable
  #(parameter width_p = 3
   ,parameter t_p     = 2
   ,parameter b_p     = 2
   )
   (input  logic [3:0][width_p-1:0] i
   ,output logic [3:0][width_p-1:0] o
   );

   // outputs of the three comparator layers
   logic [3:0][width_p-1:0] layer_a;
   logic [3:0][width_p-1:0] layer_b;
   logic [3:0][width_p-1:0] layer_c;

   // strict compare on the key field only
   // equal keys never swap
   function automatic logic key_gt
     (input logic [width_p-1:0] a
     ,input logic [width_p-1:0] b
     );
      key_gt = a[t_p:b_p] > b[t_p:b_p];
   endfunction

   // layer a, neighbours (0,1) and (2,3)
   always_comb
   begin
      layer_a = i;
      if (key_gt(i[0], i[1]))
      begin
         layer_a[0] = i[1];
         layer_a[1] = i[0];
      end
      if (key_gt(i[2], i[3]))
      begin
         layer_a[2] = i[3];
         layer_a[3] = i[2];
      end
   end

   // layer b, pairs (0,2) and (1,3)
   // after this the minimum sits at 0 and the maximum at 3
   always_comb
   begin
      layer_b = layer_a;
      if (key_gt(layer_a[0], layer_a[2]))
      begin
         layer_b[0] = layer_a[2];
         layer_b[2] = layer_a[0];
      end
      if (key_gt(layer_a[1], layer_a[3]))
      begin
         layer_b[1] = layer_a[3];
         layer_b[3] = layer_a[1];
      end
   end

   // layer c, middle pair (1,2) settles the rest
   always_comb
   begin
      layer_c = layer_b;
      if (key_gt(layer_b[1], layer_b[2]))
      begin
         layer_c[1] = layer_b[2];
         layer_c[2] = layer_b[1];
      end
   end

   assign o = layer_c;

endmodule

// ==== bsg_sbox_ctrl_concentrate.sv ====
`timescale 1ns/1ps
`include "sbox_params.svh"

// occupancy vector to concentrate / deconcentrate permutations
//
// example for vec 1011
//   output 0 <- lane 0, output 1 <- lane 1, output 2 <- lane 3, output 3 <- lane 2
//   the backward permutation is the inverse of that mapping
module bsg_sbox_ctrl_concentrate
   (input  logic [`SBOX_LANES-1:0] vec_i
   ,output sbox_pkg::lane_perm_t   fwd_perm_o
   ,output logic [`SBOX_LANES-1:0] fwd_valid_o
   ,output sbox_pkg::lane_perm_t   bkwd_perm_o
   );

   import sbox_pkg::*;

   localparam int lg_lp = `SBOX_LG_LANES;

   // forward sort items, {~vec bit, lane index}
   logic [`SBOX_LANES-1:0][lg_lp:0] fwd_sort_li;
   logic [`SBOX_LANES-1:0][lg_lp:0] fwd_sort_lo;

   // backward sort items, {forward index, output position}
   logic [`SBOX_LANES-1:0][2*lg_lp-1:0] bkwd_sort_li;
   logic [`SBOX_LANES-1:0][2*lg_lp-1:0] bkwd_sort_lo;

   // **************************************************
   // forward permutation
   // **************************************************

   // occupied lanes carry a 0 in the top bit and so sort first
   // the lane index sits in the key too, keys are all distinct,
   // so occupied lanes come out in their original order
   for (genvar j = 0; j < `SBOX_LANES; j++)
   begin : g_fwd_in
      assign fwd_sort_li[j] = {~vec_i[j], lane_idx_t'(j)};
   end

   bsg_sort_stable
     #(.width_p(lg_lp+1)
      ,.t_p    (lg_lp)
      ,.b_p    (0)
      )
   fwd_sort
      (.i(fwd_sort_li)
      ,.o(fwd_sort_lo)
      );

   // low bits name the source lane, top bit is the inverted occupancy
   for (genvar j = 0; j < `SBOX_LANES; j++)
   begin : g_fwd_out
      assign fwd_perm_o[j]  = fwd_sort_lo[j][lg_lp-1:0];
      assign fwd_valid_o[j] = ~fwd_sort_lo[j][lg_lp];
   end

   // **************************************************
   // backward permutation
   // **************************************************

   // sorting on the forward indices brings lane k to position k,
   // its tag then tells which output that lane was moved to
   for (genvar j = 0; j < `SBOX_LANES; j++)
   begin : g_bkwd_in
      assign bkwd_sort_li[j] = {fwd_perm_o[j], lane_idx_t'(j)};
   end

   bsg_sort_stable
     #(.width_p(2*lg_lp)
      ,.t_p    (2*lg_lp-1)
      ,.b_p    (lg_lp)
      )
   bkwd_sort
      (.i(bkwd_sort_li)
      ,.o(bkwd_sort_lo)
      );

   for (genvar j = 0; j < `SBOX_LANES; j++)
   begin : g_bkwd_out
      assign bkwd_perm_o[j] = bkwd_sort_lo[j][lg_lp-1:0];
   end

endmodule

// ==== sbox_route_gen.sv ====
`timescale 1ns/1ps
`include "sbox_params.svh"

// route register beside the lane buffer
// mask is decoded combinationally and captured on the same load pulse
// as the lane data, so route and data always describe one bundle
module sbox_route_gen
   (input  logic                   clk_i
   ,input  logic                   reset_i
   ,input  logic                   load_i
   ,input  logic [`SBOX_LANES-1:0] mask_i
   ,output sbox_pkg::route_s       route_o
   );

   import sbox_pkg::*;

   // combinational control outputs
   lane_perm_t             fwd_perm;
   logic [`SBOX_LANES-1:0] fwd_valid;
   lane_perm_t             bkwd_perm;

   // registered route
   route_s route_r;

   bsg_sbox_ctrl_concentrate ctrl
      (.vec_i      (mask_i)
      ,.fwd_perm_o (fwd_perm)
      ,.fwd_valid_o(fwd_valid)
      ,.bkwd_perm_o(bkwd_perm)
      );

   // **************************************************
   // route register
   // **************************************************

   // held while the stage stalls, updated only on a transfer in
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         route_r <= '0;
      end
      else if (load_i)
      begin
         route_r.fwd_perm  <= fwd_perm;
         route_r.fwd_valid <= fwd_valid;
         route_r.bkwd_perm <= bkwd_perm;
      end
   end

   assign route_o = route_r;

endmodule

// ==== sbox_lane_buffer.sv ====
`timescale 1ns/1ps

// first pipeline stage, one entry
// holds the lane data only, the mask goes to the route generator
module sbox_lane_buffer
   (input  logic                  clk_i
   ,input  logic                  reset_i
   // upstream port
   ,input  logic                  in_valid_i
   ,input  sbox_pkg::in_bundle_s  in_bundle_i
   ,output logic                  in_ready_o
   // transfer strobe for the route register
   ,output logic                  load_o
   // stage port towards the crossbar
   ,output logic                  stage_valid_o
   ,output sbox_pkg::lane_data_t  stage_data_o
   ,input  logic                  stage_ready_i
   );

   import sbox_pkg::*;

   logic       valid_r;
   lane_data_t data_r;
   logic       accept;

   // free when empty or when the crossbar drains us this cycle
   assign in_ready_o = ~valid_r | stage_ready_i;

   // one transfer in per cycle at most
   assign accept = in_valid_i & in_ready_o;

   // route generator samples the mask on exactly this pulse
   assign load_o = accept;

   // **************************************************
   // stage registers
   // **************************************************

   // valid follows the input whenever the slot opens up
   // otherwise the current bundle is held
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         valid_r <= 1'b0;
      else if (in_ready_o)
         valid_r <= in_valid_i;
   end

   // payload only moves on a real transfer
   always_ff @(posedge clk_i)
   begin
      if (accept)
         data_r <= in_bundle_i.data;
   end

   assign stage_valid_o = valid_r;
   assign stage_data_o  = data_r;

endmodule

// ==== sbox_crossbar.sv ====
`timescale 1ns/1ps
`include "sbox_params.svh"

// second pipeline stage
// routes buffered lanes through the forward permutation and
// registers the concentrated bundle for the downstream port
module sbox_crossbar
   (input  logic                  clk_i
   ,input  logic                  reset_i
   // stage port from the lane buffer
   ,input  logic                  stage_valid_i
   ,input  sbox_pkg::lane_data_t  stage_data_i
   ,input  sbox_pkg::route_s      route_i
   ,output logic                  stage_ready_o
   // downstream port
   ,output logic                  out_valid_o
   ,output sbox_pkg::out_bundle_s out_bundle_o
   ,input  logic                  out_ready_i
   );

   import sbox_pkg::*;

   out_bundle_s out_n;
   out_bundle_s out_r;
   logic        out_valid_r;
   logic        accept;

   // **************************************************
   // lane mux and popcount
   // **************************************************

   always_comb
   begin
      out_n = '0;
      for (int j = 0; j < `SBOX_LANES; j++)
      begin
         // output j pulls from the lane named by fwd_perm[j]
         // unused outputs stay zero
         if (route_i.fwd_valid[j])
            out_n.data[j] = stage_data_i[route_i.fwd_perm[j]];
         // occupied lanes counted as they pass
         out_n.count = out_n.count + {{`SBOX_LG_LANES{1'b0}}, route_i.fwd_valid[j]};
      end
      // valid bits are already packed low by the sort
      out_n.lane_valid = route_i.fwd_valid;
      out_n.bkwd_perm  = route_i.bkwd_perm;
   end

   // **************************************************
   // output register
   // **************************************************

   // room when empty or when downstream takes the current bundle
   assign stage_ready_o = ~out_valid_r | out_ready_i;
   assign accept        = stage_valid_i & stage_ready_o;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         out_valid_r <= 1'b0;
      else if (stage_ready_o)
         out_valid_r <= stage_valid_i;
   end

   // held unchanged while downstream stalls
   always_ff @(posedge clk_i)
   begin
      if (accept)
         out_r <= out_n;
   end

   assign out_valid_o  = out_valid_r;
   assign out_bundle_o = out_r;

endmodule

// ==== sbox_concentrator.sv ====
`timescale 1ns/1ps

// four lane concentrator, two register stages
// lane buffer and route register fill together, crossbar feeds the output
module sbox_concentrator
   (input  logic                  clk_i
   ,input  logic                  reset_i
   // upstream port
   ,input  logic                  in_valid_i
   ,input  sbox_pkg::in_bundle_s  in_bundle_i
   ,output logic                  in_ready_o
   // downstream port
   ,output logic                  out_valid_o
   ,output sbox_pkg::out_bundle_s out_bundle_o
   ,input  logic                  out_ready_i
   );

   import sbox_pkg::*;

   // shared load strobe between buffer and route register
   logic       load;

   // stage handshake between buffer and crossbar
   logic       stage_valid;
   logic       stage_ready;
   lane_data_t stage_data;
   route_s     route;

   sbox_lane_buffer lane_buf
      (.clk_i        (clk_i)
      ,.reset_i      (reset_i)
      ,.in_valid_i   (in_valid_i)
      ,.in_bundle_i  (in_bundle_i)
      ,.in_ready_o   (in_ready_o)
      ,.load_o       (load)
      ,.stage_valid_o(stage_valid)
      ,.stage_data_o (stage_data)
      ,.stage_ready_i(stage_ready)
      );

   // mask is taken straight off the input port
   sbox_route_gen route_gen
      (.clk_i  (clk_i)
      ,.reset_i(reset_i)
      ,.load_i (load)
      ,.mask_i (in_bundle_i.mask)
      ,.route_o(route)
      );

   sbox_crossbar xbar
      (.clk_i        (clk_i)
      ,.reset_i      (reset_i)
      ,.stage_valid_i(stage_valid)
      ,.stage_data_i (stage_data)
      ,.route_i      (route)
      ,.stage_ready_o(stage_ready)
      ,.out_valid_o  (out_valid_o)
      ,.out_bundle_o (out_bundle_o)
      ,.out_ready_i  (out_ready_i)
      );

endmodule

// ==== tb_sbox_concentrator.sv ====
`timescale 1ns/1ps
`include "sbox_params.svh"

module tb_sbox_concentrator;

   import sbox_pkg::*;

   // stream length sets the cycle budget
   // random valid and ready each run at about 75 percent
   localparam int stream_n   = 200;
   localparam int max_cycles = 4*stream_n + 200;

   logic        clk;
   logic        reset;
   logic        in_valid;
   in_bundle_s  in_bundle;
   logic        in_ready;
   logic        out_valid;
   out_bundle_s out_bundle;
   logic        out_ready;

   // scoreboard state is written by the monitor only
   out_bundle_s exp_q [$];
   in_bundle_s  sent_q [$];
   logic        in_took;
   int          in_count;
   int          cycles;
   integer      seed;

   sbox_concentrator DUT
      (.clk_i       (clk)
      ,.reset_i     (reset)
      ,.in_valid_i  (in_valid)
      ,.in_bundle_i (in_bundle)
      ,.in_ready_o  (in_ready)
      ,.out_valid_o (out_valid)
      ,.out_bundle_o(out_bundle)
      ,.out_ready_i (out_ready)
      );

   always #5 clk = ~clk;

   // **************************************************
   // checking helpers
   // **************************************************

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
         $display("test failed");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   // occupied lanes go low in input order and free lanes follow in order
   // bkwd_perm is the inverse of that whole mapping
   function automatic out_bundle_s expected_bundle(input in_bundle_s b);
      out_bundle_s e;
      lane_idx_t   order [`SBOX_LANES];
      int          n;
      e = '0;
      n = 0;
      for (int i = 0; i < `SBOX_LANES; i++)
      begin
         if (b.mask[i])
         begin
            order[n]  = lane_idx_t'(i);
            e.data[n] = b.data[i];
            n++;
         end
      end
      e.count = n[`SBOX_LG_LANES:0];
      for (int i = 0; i < n; i++)
         e.lane_valid[i] = 1'b1;
      for (int i = 0; i < `SBOX_LANES; i++)
      begin
         if (!b.mask[i])
         begin
            order[n] = lane_idx_t'(i);
            n++;
         end
      end
      for (int k = 0; k < `SBOX_LANES; k++)
         e.bkwd_perm[order[k]] = lane_idx_t'(k);
      return e;
   endfunction

   function automatic in_bundle_s random_bundle();
      in_bundle_s b;
      b.data = $random(seed);
      b.mask = $random(seed);
      return b;
   endfunction

   // pops the oldest expected bundle and compares every field
   task automatic compare_output(input out_bundle_s got);
      out_bundle_s exp;
      in_bundle_s  src;
      if (exp_q.size() == 0)
      begin
         $display("an output bundle arrived at %0t while none was expected", $time);
         $display("test failed");
         $fatal(1, "unexpected output bundle");
      end
      else
      begin
         exp = exp_q.pop_front();
         src = sent_q.pop_front();
         check("out_bundle_o.data", got.data, exp.data);
         check("out_bundle_o.lane_valid", got.lane_valid, exp.lane_valid);
         check("out_bundle_o.count", got.count, exp.count);
         check("out_bundle_o.bkwd_perm", got.bkwd_perm, exp.bkwd_perm);
         // walking back through bkwd_perm must restore each occupied lane
         for (int k = 0; k < `SBOX_LANES; k++)
         begin
            if (src.mask[k])
               check("restored lane data", got.data[got.bkwd_perm[k]], src.data[k]);
         end
      end
   endtask

   // monitor samples at the rising edge before any register update lands
   always @(posedge clk)
   begin
      in_took = 1'b0;
      if (!reset && in_valid && in_ready)
      begin
         in_took = 1'b1;
         in_count++;
         exp_q.push_back(expected_bundle(in_bundle));
         sent_q.push_back(in_bundle);
      end
      if (!reset && out_valid && out_ready)
         compare_output(out_bundle);
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= max_cycles)
      begin
         $display("run stopped after %0d cycles without finishing the tests", cycles);
         $display("test failed");
         $fatal(1, "timeout");
      end
   end

   // **************************************************
   // directed tests
   // **************************************************

   // called on a falling edge and returns on the falling edge after the transfer
   task automatic send_bundle(input in_bundle_s b);
      in_valid  = 1'b1;
      in_bundle = b;
      @(negedge clk);
      while (!in_took)
         @(negedge clk);
   endtask

   task automatic drain_outputs();
      out_ready = 1'b1;
      while (exp_q.size() != 0)
         @(negedge clk);
   endtask

   task automatic reset_test();
      repeat (8)
      begin
         @(negedge clk);
         check("out_valid_o", out_valid, 1'b0);
         check("in_ready_o", in_ready, 1'b1);
      end
      reset = 1'b0;
      @(negedge clk);
      check("out_valid_o", out_valid, 1'b0);
      check("in_ready_o", in_ready, 1'b1);
   endtask

   task automatic mask_sweep_test();
      in_bundle_s b;
      out_ready = 1'b1;
      for (int m = 0; m < 16; m++)
      begin
         b.mask = m[`SBOX_LANES-1:0];
         // lane data tagged with mask and lane number
         for (int i = 0; i < `SBOX_LANES; i++)
            b.data[i] = 8'((m << 4) | i);
         send_bundle(b);
      end
      in_valid = 1'b0;
      drain_outputs();
   endtask

   task automatic backpressure_test();
      out_bundle_s held;
      int          start;
      out_ready = 1'b0;
      start     = in_count;
      in_bundle = random_bundle();
      in_valid  = 1'b1;
      repeat (6)
      begin
         @(negedge clk);
         if (in_took)
            in_bundle = random_bundle();
      end
      // both stages are full and the third bundle waits at the input
      check("bundles accepted under stall", in_count - start, 2);
      check("in_ready_o", in_ready, 1'b0);
      check("out_valid_o", out_valid, 1'b1);
      held = out_bundle;
      repeat (4)
      begin
         @(negedge clk);
         check("held out_bundle_o", out_bundle, held);
         check("in_ready_o", in_ready, 1'b0);
      end
      out_ready = 1'b1;
      // the freed output register lets the waiting bundle in on the next edge
      @(negedge clk);
      in_valid = 1'b0;
      drain_outputs();
      check("bundles accepted after release", in_count - start, 3);
   endtask

   task automatic streaming_test();
      int target;
      int issued;
      target = in_count + stream_n;
      issued = 0;
      while (in_count < target)
      begin
         @(negedge clk);
         out_ready = ($random(seed) & 3) != 0;
         // a new bundle only once the previous one has transferred
         if (!in_valid || in_took)
         begin
            if (issued < stream_n && ($random(seed) & 3) != 0)
            begin
               in_valid  = 1'b1;
               in_bundle = random_bundle();
               issued++;
            end
            else
               in_valid = 1'b0;
         end
      end
      in_valid = 1'b0;
      drain_outputs();
   endtask

   initial
   begin
      seed      = 10;
      clk       = 1'b0;
      reset     = 1'b1;
      in_valid  = 1'b0;
      in_bundle = '0;
      out_ready = 1'b1;
      in_took   = 1'b0;
      in_count  = 0;
      cycles    = 0;
      reset_test();
      mask_sweep_test();
      backpressure_test();
      streaming_test();
      // every expected bundle has left, so the output must be empty now
      if (!out_valid)
      begin
         $display("test passed");
         $finish;
      end
      else
      begin
         $display("test failed");
         $fatal(1, "an extra bundle was still at the output after the stream drained");
      end
   end

endmodule

// ==== src.f ====
+incdir+.
sbox_pkg.sv
bsg_sort_stable.sv
bsg_sbox_ctrl_concentrate.sv
sbox_route_gen.sv
sbox_lane_buffer.sv
sbox_crossbar.sv
sbox_concentrator.sv
tb_sbox_concentrator.sv

// ==== Makefile ====
# Verilator build for the concentrator testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       := tb_sbox_concentrator
FILELIST  := src.f
BUILD_DIR := obj_dir

SOURCES := $(wildcard *.sv) $(wildcard *.svh)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulation is the test result
run: compile
	./$(BINARY)

clean:
	rm -rf $(BUILD_DIR)
